// ==== rtl/lu_num_pkg.sv ====
`default_nettype none

package lu_num_pkg;

    // ########################################
    // Q16.16 data word
    // ########################################

    typedef logic signed [31:0] fix_t;

    localparam int FRAC_BITS = 16;

    localparam fix_t FIX_ONE  = 32'sh0001_0000;
    localparam fix_t FIX_ZERO = 32'sh0000_0000;

    // ########################################
    // arithmetic helpers
    // ########################################

    // full product, arithmetic shift rounds toward -inf
    function automatic fix_t fix_mul(fix_t a, fix_t b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] prod;
        logic signed [63:0] shifted;
        wide_a  = a;
        wide_b  = b;
        prod    = wide_a * wide_b;
        shifted = prod >>> FRAC_BITS;
        return shifted[31:0];
    endfunction

    // pre-scaled dividend, quotient truncates toward zero
    function automatic fix_t fix_div(fix_t num, fix_t den);
        logic signed [63:0] wide_num;
        logic signed [63:0] wide_den;
        logic signed [63:0] quot;
        wide_num = num;
        wide_num = wide_num <<< FRAC_BITS;
        wide_den = den;
        quot     = wide_num / wide_den;
        return quot[31:0];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/lu_sched_pkg.sv ====
`default_nettype none

package lu_sched_pkg;

    // ########################################
    // array schedule
    // ########################################

    typedef logic [5:0] step_t;

    // marker for a row that gets no matrix element this step
    localparam int FEED_NONE = -1;

    // column of mat_in loaded into a row's feed register at step s
    function automatic int feed_col(step_t s, int row, int matsize);
        int col;
        col = int'(s) - row;
        if (col >= 0 && col < matsize) begin
            return col;
        end
        return FEED_NONE;
    endfunction

    // U row k leaves the bottom of column k one entry per step
    function automatic step_t u_capture_step(int matsize, int k, int m);
        return step_t'(matsize + 1 + k + m);
    endfunction

    // last entry is in place once the count gets here
    function automatic step_t done_step(int matsize);
        return step_t'(3 * matsize);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/lu_feed_skew.sv ====
`timescale 1ns/10ps
`default_nettype none

module lu_feed_skew
    import lu_num_pkg::*, lu_sched_pkg::*;
#(
    parameter int MATSIZE = 3
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic vld,
    input  wire logic en,
    input  fix_t      mat_in [MATSIZE][MATSIZE],
    output fix_t      row_word [MATSIZE],
    output step_t     step
);

    localparam step_t LAST_STEP = done_step(MATSIZE);

    // ########################################
    // step counter
    // ########################################

    // saturates so the schedule stays parked after done
    always_ff @(posedge clk) begin
        if (rst || !vld) begin
            step <= '0;
        end else if (en && step != LAST_STEP) begin
            step <= step + 1'b1;
        end
    end

    // ########################################
    // skewed row feed
    // ########################################

    for (genvar r = 0; r < MATSIZE; r++) begin : g_row
        fix_t word_d;
        int   col_sel;

        // row r runs r steps behind row 0
        always_comb begin
            col_sel = feed_col(step, r, MATSIZE);
            word_d  = FIX_ZERO;
            for (int c = 0; c < MATSIZE; c++) begin
                if (col_sel == c) begin
                    word_d = mat_in[r][c];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rst || !vld) begin
                row_word[r] <= FIX_ZERO;
            end else if (en) begin
                row_word[r] <= word_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lu_elim_pe.sv ====
`timescale 1ns/10ps
`default_nettype none

module lu_elim_pe
    import lu_num_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic vld,
    input  wire logic en,
    input  fix_t      a_in,
    input  fix_t      u_in,
    output fix_t      a_out,
    output fix_t      u_out,
    output fix_t      l
);

    logic taken;
    logic take;
    fix_t quot;
    fix_t elim;
    fix_t a_q;
    fix_t u_q;
    fix_t l_q;

    // ########################################
    // datapath
    // ########################################

    // first nonzero word down the column is the pivot u_jj
    assign take = !taken && (u_in != FIX_ZERO);

    assign quot = fix_div(a_in, u_in);

    // l_q is still zero before the take, so the row passes unchanged
    assign elim = a_in - fix_mul(l_q, u_in);

    // ########################################
    // multiplier
    // ########################################

    always_ff @(posedge clk) begin
        if (rst || !vld) begin
            taken <= 1'b0;
            l_q   <= FIX_ZERO;
        end else if (en && take) begin
            taken <= 1'b1;
            l_q   <= quot;
        end
    end

    // ########################################
    // row and column streams
    // ########################################

    always_ff @(posedge clk) begin
        if (rst || !vld) begin
            a_q <= FIX_ZERO;
        end else if (en) begin
            // eliminated entry leaves the row as zero
            if (take) begin
                a_q <= FIX_ZERO;
            end else begin
                a_q <= elim;
            end
        end
    end

    // U word moves on to the cell below
    always_ff @(posedge clk) begin
        if (rst || !vld) begin
            u_q <= FIX_ZERO;
        end else if (en) begin
            u_q <= u_in;
        end
    end

    assign a_out = a_q;
    assign u_out = u_q;
    assign l     = l_q;

endmodule

`default_nettype wire

// ==== rtl/lu_result_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module lu_result_capture
    import lu_num_pkg::*, lu_sched_pkg::*;
#(
    parameter int MATSIZE = 3
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic vld,
    input  wire logic en,
    input  step_t     step,
    input  fix_t      col_bottom [MATSIZE],
    output fix_t      u_upper [MATSIZE][MATSIZE],
    output logic      done
);

    localparam step_t DONE_AT = done_step(MATSIZE);

    // ########################################
    // U capture
    // ########################################

    // column k carries U row k past the bottom cell in order
    always_ff @(posedge clk) begin
        if (rst || !vld) begin
            for (int k = 0; k < MATSIZE; k++) begin
                for (int m = 0; m < MATSIZE; m++) begin
                    u_upper[k][m] <= FIX_ZERO;
                end
            end
        end else if (en) begin
            for (int k = 0; k < MATSIZE; k++) begin
                for (int m = 0; m < MATSIZE; m++) begin
                    if (m < k) begin
                        u_upper[k][m] <= FIX_ZERO;
                    end else if (step == u_capture_step(MATSIZE, k, m)) begin
                        u_upper[k][m] <= col_bottom[k];
                    end
                end
            end
        end
    end

    // ########################################
    // done
    // ########################################

    // set on the edge that moves the count onto DONE_AT
    always_ff @(posedge clk) begin
        if (rst || !vld) begin
            done <= 1'b0;
        end else if (en && step >= DONE_AT - 1) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lu_systolic.sv ====
`timescale 1ns/10ps
`default_nettype none

module lu_systolic
    import lu_num_pkg::*, lu_sched_pkg::*;
#(
    parameter int MATSIZE = 3
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic vld,
    input  wire logic en,
    input  fix_t      mat_in [MATSIZE][MATSIZE],
    output fix_t      l_out [MATSIZE][MATSIZE],
    output fix_t      u_out [MATSIZE][MATSIZE],
    output logic      done
);

    fix_t  row_word [MATSIZE];
    step_t step;
    fix_t  piv_q [MATSIZE];
    fix_t  pe_a [MATSIZE][MATSIZE];
    fix_t  pe_u [MATSIZE][MATSIZE];
    fix_t  col_bottom [MATSIZE];
    fix_t  u_upper [MATSIZE][MATSIZE];

    lu_feed_skew #(
        .MATSIZE(MATSIZE)
    ) i_lu_feed_skew (
        .clk     (clk),
        .rst     (rst),
        .vld     (vld),
        .en      (en),
        .mat_in  (mat_in),
        .row_word(row_word),
        .step    (step)
    );

    // ########################################
    // cell triangle and pivots
    // ########################################

    for (genvar i = 0; i < MATSIZE; i++) begin : g_row
        for (genvar j = 0; j < i; j++) begin : g_cell
            fix_t a_src;
            fix_t u_src;

            if (j == 0) begin : g_a_feed
                assign a_src = row_word[i];
            end else begin : g_a_link
                assign a_src = pe_a[i][j-1];
            end

            // cell right under the diagonal listens to the pivot
            if (i == j + 1) begin : g_u_piv
                assign u_src = piv_q[j];
            end else begin : g_u_link
                assign u_src = pe_u[i-1][j];
            end

            lu_elim_pe i_lu_elim_pe (
                .clk  (clk),
                .rst  (rst),
                .vld  (vld),
                .en   (en),
                .a_in (a_src),
                .u_in (u_src),
                .a_out(pe_a[i][j]),
                .u_out(pe_u[i][j]),
                .l    (l_out[i][j])
            );
        end

        fix_t piv_src;

        if (i == 0) begin : g_piv_feed
            assign piv_src = row_word[0];
        end else begin : g_piv_link
            assign piv_src = pe_a[i][i-1];
        end

        // diagonal register, row i once fully eliminated
        always_ff @(posedge clk) begin
            if (rst || !vld) begin
                piv_q[i] <= FIX_ZERO;
            end else if (en) begin
                piv_q[i] <= piv_src;
            end
        end

        if (i == MATSIZE - 1) begin : g_bot_piv
            assign col_bottom[i] = piv_q[i];
        end else begin : g_bot_cell
            assign col_bottom[i] = pe_u[MATSIZE-1][i];
        end
    end

    lu_result_capture #(
        .MATSIZE(MATSIZE)
    ) i_lu_result_capture (
        .clk       (clk),
        .rst       (rst),
        .vld       (vld),
        .en        (en),
        .step      (step),
        .col_bottom(col_bottom),
        .u_upper   (u_upper),
        .done      (done)
    );

    // ########################################
    // fixed parts of L and U
    // ########################################

    for (genvar i = 0; i < MATSIZE; i++) begin : g_out_row
        for (genvar j = 0; j < MATSIZE; j++) begin : g_out_col
            if (i == j) begin : g_diag
                assign l_out[i][j] = FIX_ONE;
                assign u_out[i][j] = u_upper[i][j];
            end else if (j > i) begin : g_upper
                assign l_out[i][j] = FIX_ZERO;
                assign u_out[i][j] = u_upper[i][j];
            end else begin : g_lower
                assign u_out[i][j] = FIX_ZERO;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/lu_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module lu_chk
    import lu_num_pkg::*;
#(
    parameter int MATSIZE = 3
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic vld,
    input wire logic en,
    input wire fix_t l_out [MATSIZE][MATSIZE],
    input wire fix_t u_out [MATSIZE][MATSIZE],
    input wire logic done
);

    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // ########################################
    // done
    // ########################################

    a_done_rst : assert property (@(posedge clk) rst |=> !done)
        else begin
            $error("done high the cycle after rst");
            fail_cnt++;
        end

    a_done_hold : assert property (@(posedge clk) (vld && !rst && !en) |=> $stable(done))
        else begin
            $error("done moved while en was low");
            fail_cnt++;
        end

    // sticky until vld drops
    a_done_sticky : assert property (@(posedge clk) (done && vld && !rst) |=> done)
        else begin
            $error("done fell while vld stayed high");
            fail_cnt++;
        end

    // ########################################
    // L and U entries
    // ########################################

    for (genvar i = 0; i < MATSIZE; i++) begin : g_row
        for (genvar j = 0; j < MATSIZE; j++) begin : g_col
            a_l_hold : assert property (@(posedge clk)
                (vld && !rst && !en) |=> $stable(l_out[i][j]))
                else begin
                    $error("l_out entry moved while en was low");
                    fail_cnt++;
                end

            a_u_hold : assert property (@(posedge clk)
                (vld && !rst && !en) |=> $stable(u_out[i][j]))
                else begin
                    $error("u_out entry moved while en was low");
                    fail_cnt++;
                end

            if (i == j) begin : g_diag
                a_l_one : assert property (@(posedge clk) l_out[i][j] == FIX_ONE)
                    else begin
                        $error("L diagonal entry is not one");
                        fail_cnt++;
                    end
            end else if (j > i) begin : g_upper
                a_l_zero : assert property (@(posedge clk) l_out[i][j] == FIX_ZERO)
                    else begin
                        $error("L upper entry is not zero");
                        fail_cnt++;
                    end
            end else begin : g_lower
                a_u_zero : assert property (@(posedge clk) u_out[i][j] == FIX_ZERO)
                    else begin
                        $error("U lower entry is not zero");
                        fail_cnt++;
                    end
            end
        end
    end

endmodule

bind lu_systolic lu_chk #(
    .MATSIZE(MATSIZE)
) i_lu_chk (
    .clk  (clk),
    .rst  (rst),
    .vld  (vld),
    .en   (en),
    .l_out(l_out),
    .u_out(u_out),
    .done (done)
);

`default_nettype wire

// ==== dv/lu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lu_tb
    import lu_num_pkg::*, lu_sched_pkg::*;
();

    localparam int MATSIZE     = 3;
    localparam int CLK_PERIOD  = 100;
    localparam int DONE_STEP   = int'(done_step(MATSIZE));
    localparam int RUN_LIMIT   = (DONE_STEP + 20) * 2;
    localparam int N_TESTS     = 6;
    localparam int N_RANDOM    = 10;
    localparam int WATCHDOG_NS = N_TESTS * (DONE_STEP + 20) * 4 * CLK_PERIOD;

    logic clk;
    logic rst;
    logic vld;
    logic en;
    fix_t mat_in [MATSIZE][MATSIZE];
    fix_t l_out [MATSIZE][MATSIZE];
    fix_t u_out [MATSIZE][MATSIZE];
    logic done;

    fix_t mat_src [MATSIZE][MATSIZE];
    fix_t exp_l [MATSIZE][MATSIZE];
    fix_t exp_u [MATSIZE][MATSIZE];
    fix_t saved [N_RANDOM][MATSIZE][MATSIZE];
    int   n_checks;
    int   n_errors;
    int   n_tests;
    int   test_err0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lu_systolic #(
        .MATSIZE(MATSIZE)
    ) i_lu_systolic (
        .clk   (clk),
        .rst   (rst),
        .vld   (vld),
        .en    (en),
        .mat_in(mat_in),
        .l_out (l_out),
        .u_out (u_out),
        .done  (done)
    );

    // ########################################
    // compare and report
    // ########################################

    task automatic check_fix(input string name, input fix_t act, input fix_t expd);
        n_checks++;
        if (act !== expd) begin
            n_errors++;
            $display("** Error: %s = %h, expected %h", name, act, expd);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic expd);
        n_checks++;
        if (act !== expd) begin
            n_errors++;
            $display("** Error: %s = %h, expected %h", name, act, expd);
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %-10s %s, %0d errors", name,
                 (n_errors == test_err0) ? "ok" : "FAILED", n_errors - test_err0);
    endtask

    // ########################################
    // reference model
    // ########################################

    // Doolittle by rows in the same elimination order as the cells
    task automatic lu_model();
        fix_t w [MATSIZE];
        fix_t lij;
        for (int i = 0; i < MATSIZE; i++) begin
            for (int m = 0; m < MATSIZE; m++) begin
                w[m]        = mat_src[i][m];
                exp_l[i][m] = (m == i) ? FIX_ONE : FIX_ZERO;
                exp_u[i][m] = FIX_ZERO;
            end
            for (int j = 0; j < i; j++) begin
                lij         = fix_div(w[j], exp_u[j][j]);
                exp_l[i][j] = lij;
                for (int m = j + 1; m < MATSIZE; m++) begin
                    w[m] = w[m] - fix_mul(lij, exp_u[j][m]);
                end
            end
            for (int m = i; m < MATSIZE; m++) begin
                exp_u[i][m] = w[m];
            end
        end
    endtask

    // ########################################
    // stimulus
    // ########################################

    // diagonal in [16, 20] and off diagonal in [-4, 4)
    task automatic random_matrix();
        for (int r = 0; r < MATSIZE; r++) begin
            for (int c = 0; c < MATSIZE; c++) begin
                if (r == c) begin
                    mat_src[r][c] = 16 * FIX_ONE + fix_t'($urandom_range(4 * 65536));
                end else begin
                    mat_src[r][c] = fix_t'($urandom_range(8 * 65536 - 1)) - 4 * FIX_ONE;
                end
            end
        end
    endtask

    // one cleared cycle before the new matrix goes in
    task automatic start_run();
        vld = 1'b0;
        en  = 1'b0;
        @(negedge clk);
        mat_in = mat_src;
        vld    = 1'b1;
    endtask

    task automatic run_enabled(input int n);
        repeat (n) begin
            en = 1'b1;
            @(negedge clk);
        end
        en = 1'b0;
    endtask

    // done must track the count of enabled edges exactly
    task automatic run_to_done(input int stall_pct);
        int n_en;
        int cycles;
        n_en   = 0;
        cycles = 0;
        while (done !== 1'b1 && cycles < RUN_LIMIT) begin
            en = ($urandom_range(99) >= stall_pct);
            @(posedge clk);
            if (en) begin
                n_en++;
            end
            @(negedge clk);
            cycles++;
            check_bit("done", done, n_en >= DONE_STEP);
        end
        en = 1'b0;
        if (done !== 1'b1) begin
            n_errors++;
            $display("done never rose within %0d cycles", RUN_LIMIT);
        end
    endtask

    task automatic check_lu();
        check_bit("done", done, 1'b1);
        for (int i = 0; i < MATSIZE; i++) begin
            for (int j = 0; j < MATSIZE; j++) begin
                check_fix($sformatf("l_out[%0d][%0d]", i, j), l_out[i][j], exp_l[i][j]);
                check_fix($sformatf("u_out[%0d][%0d]", i, j), u_out[i][j], exp_u[i][j]);
            end
        end
    endtask

    task automatic check_cleared();
        check_bit("done", done, 1'b0);
        for (int i = 0; i < MATSIZE; i++) begin
            for (int j = 0; j < MATSIZE; j++) begin
                if (j < i) begin
                    check_fix($sformatf("l_out[%0d][%0d]", i, j), l_out[i][j], FIX_ZERO);
                end else begin
                    check_fix($sformatf("u_out[%0d][%0d]", i, j), u_out[i][j], FIX_ZERO);
                end
            end
        end
    endtask

    // ########################################
    // directed tests
    // ########################################

    task automatic test_identity();
        test_err0 = n_errors;
        for (int r = 0; r < MATSIZE; r++) begin
            for (int c = 0; c < MATSIZE; c++) begin
                mat_src[r][c] = (r == c) ? FIX_ONE : FIX_ZERO;
            end
        end
        exp_l = mat_src;
        exp_u = mat_src;
        start_run();
        run_to_done(0);
        check_lu();
        end_test("identity");
    endtask

    task automatic test_known_matrix();
        int a [MATSIZE][MATSIZE];
        int l [MATSIZE][MATSIZE];
        int u [MATSIZE][MATSIZE];
        test_err0 = n_errors;
        a = '{'{2, 1, 1}, '{4, 3, 3}, '{8, 7, 9}};
        l = '{'{1, 0, 0}, '{2, 1, 0}, '{4, 3, 1}};
        u = '{'{2, 1, 1}, '{0, 1, 1}, '{0, 0, 2}};
        for (int r = 0; r < MATSIZE; r++) begin
            for (int c = 0; c < MATSIZE; c++) begin
                mat_src[r][c] = fix_t'(a[r][c]) * FIX_ONE;
                exp_l[r][c]   = fix_t'(l[r][c]) * FIX_ONE;
                exp_u[r][c]   = fix_t'(u[r][c]) * FIX_ONE;
            end
        end
        start_run();
        run_to_done(0);
        check_lu();
        end_test("known");
    endtask

    task automatic test_random();
        test_err0 = n_errors;
        for (int t = 0; t < N_RANDOM; t++) begin
            random_matrix();
            saved[t] = mat_src;
            start_run();
            run_to_done(0);
            lu_model();
            check_lu();
        end
        end_test("random");
    endtask

    // same matrices again with en low on about a quarter of the cycles
    task automatic test_stalls();
        test_err0 = n_errors;
        for (int t = 0; t < N_RANDOM; t++) begin
            mat_src = saved[t];
            start_run();
            run_to_done(25);
            lu_model();
            check_lu();
        end
        end_test("stalls");
    endtask

    task automatic test_restart();
        test_err0 = n_errors;
        random_matrix();
        start_run();
        run_enabled(DONE_STEP - 3);
        vld = 1'b0;
        @(negedge clk);
        check_cleared();
        random_matrix();
        start_run();
        run_to_done(0);
        lu_model();
        check_lu();
        end_test("restart");
    endtask

    // vld stays high through rst, so the run starts over
    task automatic test_reset();
        test_err0 = n_errors;
        random_matrix();
        start_run();
        run_enabled(DONE_STEP + 2);
        rst = 1'b1;
        @(negedge clk);
        check_cleared();
        rst = 1'b0;
        run_to_done(0);
        lu_model();
        check_lu();
        end_test("reset");
    endtask

    // ########################################
    // main sequence and watchdog
    // ########################################

    initial begin
        void'($urandom(32'h8b27));
        clk      = 1'b0;
        rst      = 1'b1;
        vld      = 1'b0;
        en       = 1'b0;
        n_checks = 0;
        n_errors = 0;
        n_tests  = 0;
        for (int r = 0; r < MATSIZE; r++) begin
            for (int c = 0; c < MATSIZE; c++) begin
                mat_in[r][c] = FIX_ZERO;
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_identity();
        test_known_matrix();
        test_random();
        test_stalls();
        test_restart();
        test_reset();
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, i_lu_systolic.i_lu_chk.fail_cnt);
        if (n_errors == 0 && i_lu_systolic.i_lu_chk.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/lu_num_pkg.sv
rtl/lu_sched_pkg.sv
rtl/lu_feed_skew.sv
rtl/lu_elim_pe.sv
rtl/lu_result_capture.sv
rtl/lu_systolic.sv
dv/lu_chk.sv
dv/lu_tb.sv
